// ==== mips_core.f ====
src/mips_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
verification/mips_core_tb.sv

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
(
   input  logic                              CLK,
   input  logic                              RESET,
   input  mips_pkg::if_id_t                  if_id,
   input  mips_pkg::retire_t                 retire,
   output mips_pkg::id_ex_t                  id_ex,
   output logic                              stall,
   output logic                              redirect,
   output logic [mips_pkg::word_width-1:0]   redirect_pc
);

   mips_pkg::instr_t                  instr;
   mips_pkg::ctrl_t                   ctrl;
   logic [mips_pkg::word_width-1:0]   rs_data;
   logic [mips_pkg::word_width-1:0]   rt_data;
   logic [mips_pkg::word_width-1:0]   imm_ext;
   logic [mips_pkg::word_width-1:0]   upper;
   logic                              taken;

   assign instr   = if_id.instr;
   assign imm_ext = {{(mips_pkg::word_width-16){instr.i.imm[15]}}, instr.i.imm};
   assign upper   = {instr.i.imm, 16'b0};

   register_file regs_i
   (
      .CLK        (CLK),
      .RESET      (RESET),
      .rs_addr    (instr.r.rs),
      .rt_addr    (instr.r.rt),
      .write_en   (retire.valid),
      .write_addr (retire.dst),
      .write_data (retire.data),
      .rs_data    (rs_data),
      .rt_data    (rt_data)
   );

   ////////////////////////////////////////////////////////////
   // Control decode
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      ctrl = '0;
      case (instr.r.opcode)
         mips_pkg::op_rtype:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_dst   = 1'b1;
            case (instr.r.funct)
               mips_pkg::fn_add: ctrl.alu_op = mips_pkg::alu_add;
               mips_pkg::fn_sub: ctrl.alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and: ctrl.alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:  ctrl.alu_op = mips_pkg::alu_or;
               mips_pkg::fn_slt: ctrl.alu_op = mips_pkg::alu_slt;
               // Unknown funct is a no-op
               default:          ctrl = '0;
            endcase
         end
         mips_pkg::op_addi:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         mips_pkg::op_lw:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.wb_sel    = mips_pkg::wb_load;
         end
         mips_pkg::op_sw:
         begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
         end
         mips_pkg::op_lui:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.wb_sel    = mips_pkg::wb_upper;
         end
         mips_pkg::op_beq: ctrl.branch_eq = 1'b1;
         mips_pkg::op_bne: ctrl.branch_ne = 1'b1;
         mips_pkg::op_j:   ctrl.jump      = 1'b1;
         default:          ctrl = '0;
      endcase
   end

   // Load in execute feeding this instruction
   assign stall = id_ex.ctrl.mem_read
                  && (id_ex.rt == instr.r.rs || id_ex.rt == instr.r.rt);

   // Branch compare on register file values, no forwarding
   assign taken = (ctrl.branch_eq && (rs_data == rt_data))
                  || (ctrl.branch_ne && (rs_data != rt_data))
                  || ctrl.jump;

   assign redirect = taken && !stall;
   assign redirect_pc = ctrl.jump
                        ? {{(mips_pkg::word_width-26){1'b0}}, instr.j.index}
                        : if_id.pc_plus1 + imm_ext;

   ////////////////////////////////////////////////////////////
   // Decode/execute register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         id_ex <= '0;
      else if (stall)
         id_ex <= '0;
      else
      begin
         id_ex.ctrl     <= ctrl;
         id_ex.pc_plus1 <= if_id.pc_plus1;
         id_ex.rs_data  <= rs_data;
         id_ex.rt_data  <= rt_data;
         id_ex.imm_ext  <= imm_ext;
         id_ex.upper    <= upper;
         id_ex.rs       <= instr.r.rs;
         id_ex.rt       <= instr.r.rt;
         id_ex.rd       <= instr.r.rd;
      end
   end

   a_mem_excl: assert property (@(posedge CLK) disable iff (RESET)
      !(id_ex.ctrl.mem_read && id_ex.ctrl.mem_write));

   a_stall_redirect: assert property (@(posedge CLK) disable iff (RESET)
      !(stall && redirect));

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
(
   input  logic               CLK,
   input  logic               RESET,
   input  mips_pkg::id_ex_t   id_ex,
   input  mips_pkg::ex_mem_t  mem_fwd,
   input  mips_pkg::retire_t  wb_fwd,
   output mips_pkg::ex_mem_t  ex_mem
);

   logic [mips_pkg::word_width-1:0]     mem_value;
   logic [mips_pkg::word_width-1:0]     op_a;
   logic [mips_pkg::word_width-1:0]     op_b_reg;
   logic [mips_pkg::word_width-1:0]     op_b;
   logic [mips_pkg::word_width-1:0]     result;
   logic [mips_pkg::reg_addr_width-1:0] dst;

   // Value the memory stage will write back
   // The load-use stall keeps a load from ever feeding execute from here
   assign mem_value = (mem_fwd.ctrl.wb_sel == mips_pkg::wb_upper)
                      ? mem_fwd.upper : mem_fwd.alu_result;

   ////////////////////////////////////////////////////////////
   // Forwarding
   ////////////////////////////////////////////////////////////
   function automatic logic [mips_pkg::word_width-1:0] forward
   (
      input logic [mips_pkg::reg_addr_width-1:0] src,
      input logic [mips_pkg::word_width-1:0]     reg_value,
      input mips_pkg::ex_mem_t                   mem_src,
      input logic [mips_pkg::word_width-1:0]     mem_src_value,
      input mips_pkg::retire_t                   wb_src
   );
      // Newer result wins
      if (mem_src.ctrl.reg_write && mem_src.dst != '0 && mem_src.dst == src)
         return mem_src_value;
      else if (wb_src.valid && wb_src.dst == src)
         return wb_src.data;
      else
         return reg_value;
   endfunction

   assign op_a     = forward(id_ex.rs, id_ex.rs_data, mem_fwd, mem_value, wb_fwd);
   assign op_b_reg = forward(id_ex.rt, id_ex.rt_data, mem_fwd, mem_value, wb_fwd);
   assign op_b     = id_ex.ctrl.alu_src ? id_ex.imm_ext : op_b_reg;

   ////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      case (id_ex.ctrl.alu_op)
         mips_pkg::alu_add: result = op_a + op_b;
         mips_pkg::alu_sub: result = op_a - op_b;
         mips_pkg::alu_and: result = op_a & op_b;
         mips_pkg::alu_or:  result = op_a | op_b;
         mips_pkg::alu_slt: result = {{(mips_pkg::word_width-1){1'b0}},
                                      $signed(op_a) < $signed(op_b)};
         default:           result = '0;
      endcase
   end

   assign dst = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         ex_mem <= '0;
      else
      begin
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.alu_result <= result;
         ex_mem.store_data <= op_b_reg;
         ex_mem.upper      <= id_ex.upper;
         ex_mem.dst        <= dst;
      end
   end

   a_alu_op_legal: assert property (@(posedge CLK) disable iff (RESET)
      id_ex.ctrl.alu_op inside {mips_pkg::alu_add, mips_pkg::alu_sub, mips_pkg::alu_and,
                                mips_pkg::alu_or, mips_pkg::alu_slt});

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
(
   input  logic                                  CLK,
   input  logic                                  RESET,
   input  logic                                  prog_write,
   input  logic [mips_pkg::imem_addr_width-1:0]  prog_addr,
   input  logic [mips_pkg::word_width-1:0]       prog_data,
   input  logic                                  stall,
   input  logic                                  redirect,
   input  logic [mips_pkg::word_width-1:0]       redirect_pc,
   output mips_pkg::if_id_t                      if_id
);

   logic [mips_pkg::word_width-1:0] imem [mips_pkg::imem_depth];
   logic [mips_pkg::word_width-1:0] pc;
   logic [mips_pkg::word_width-1:0] pc_plus1;
   logic [mips_pkg::word_width-1:0] instr;

   assign pc_plus1 = pc + 1'b1;
   assign instr    = imem[pc[mips_pkg::imem_addr_width-1:0]];

   // Program load port
   always_ff @(posedge CLK)
   begin
      if (prog_write)
         imem[prog_addr] <= prog_data;
   end

   ////////////////////////////////////////////////////////////
   // PC and fetch/decode register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         pc    <= '0;
         if_id <= '0;
      end
      else if (redirect)
      begin
         // Drop the wrong-path fetch
         pc    <= redirect_pc;
         if_id <= '0;
      end
      else if (!stall)
      begin
         pc             <= pc_plus1;
         if_id.instr    <= instr;
         if_id.pc_plus1 <= pc_plus1;
      end
   end

   // Loading is only allowed while the core is held in reset
   a_prog_in_reset: assert property (@(posedge CLK) prog_write |-> RESET);

endmodule

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage
(
   input  logic               CLK,
   input  logic               RESET,
   input  mips_pkg::ex_mem_t  ex_mem,
   output mips_pkg::retire_t  retire
);

   logic [mips_pkg::word_width-1:0]      dmem [mips_pkg::dmem_depth];
   logic [mips_pkg::dmem_addr_width-1:0] addr;
   logic [mips_pkg::word_width-1:0]      load_data;
   logic [mips_pkg::word_width-1:0]      wb_value;

   // Word addressed by the low result bits
   assign addr      = ex_mem.alu_result[mips_pkg::dmem_addr_width-1:0];
   assign load_data = dmem[addr];

   always_ff @(posedge CLK)
   begin
      if (ex_mem.ctrl.mem_write)
         dmem[addr] <= ex_mem.store_data;
   end

   always_comb
   begin
      case (ex_mem.ctrl.wb_sel)
         mips_pkg::wb_load:  wb_value = load_data;
         mips_pkg::wb_upper: wb_value = ex_mem.upper;
         default:            wb_value = ex_mem.alu_result;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Memory/write-back register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         retire <= '0;
      else
      begin
         retire.valid <= ex_mem.ctrl.reg_write && (ex_mem.dst != '0);
         retire.dst   <= ex_mem.dst;
         retire.data  <= wb_value;
      end
   end

   a_retire_dst: assert property (@(posedge CLK) disable iff (RESET)
      retire.valid |-> retire.dst != '0);

endmodule

// ==== src/mips_core.sv ====
`timescale 1ns/1ps

module mips_core
(
   input  logic                                  CLK,
   input  logic                                  RESET,
   input  logic                                  prog_write,
   input  logic [mips_pkg::imem_addr_width-1:0]  prog_addr,
   input  logic [mips_pkg::word_width-1:0]       prog_data,
   output mips_pkg::retire_t                     retire
);

   mips_pkg::if_id_t                  if_id;
   mips_pkg::id_ex_t                  id_ex;
   mips_pkg::ex_mem_t                 ex_mem;
   logic                              stall;
   logic                              redirect;
   logic [mips_pkg::word_width-1:0]   redirect_pc;

   fetch_stage fetch_i
   (
      .CLK         (CLK),
      .RESET       (RESET),
      .prog_write  (prog_write),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .if_id       (if_id)
   );

   // Branches resolve here, register file writes come back from write-back
   decode_stage decode_i
   (
      .CLK         (CLK),
      .RESET       (RESET),
      .if_id       (if_id),
      .retire      (retire),
      .id_ex       (id_ex),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   execute_stage execute_i
   (
      .CLK     (CLK),
      .RESET   (RESET),
      .id_ex   (id_ex),
      .mem_fwd (ex_mem),
      .wb_fwd  (retire),
      .ex_mem  (ex_mem)
   );

   memory_stage memory_i
   (
      .CLK    (CLK),
      .RESET  (RESET),
      .ex_mem (ex_mem),
      .retire (retire)
   );

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and depths
   ////////////////////////////////////////////////////////////
   localparam int word_width      = 32;
   localparam int reg_addr_width  = 5;
   localparam int imem_depth      = 256;
   localparam int dmem_depth      = 256;
   localparam int imem_addr_width = 8;
   localparam int dmem_addr_width = 8;

   // Primary opcodes
   localparam logic [5:0] op_rtype = 6'd0;
   localparam logic [5:0] op_j     = 6'd2;
   localparam logic [5:0] op_beq   = 6'd4;
   localparam logic [5:0] op_bne   = 6'd5;
   localparam logic [5:0] op_addi  = 6'd8;
   localparam logic [5:0] op_lui   = 6'd15;
   localparam logic [5:0] op_lw    = 6'd35;
   localparam logic [5:0] op_sw    = 6'd43;

   // R-type function codes
   localparam logic [5:0] fn_add = 6'd32;
   localparam logic [5:0] fn_sub = 6'd34;
   localparam logic [5:0] fn_and = 6'd36;
   localparam logic [5:0] fn_or  = 6'd37;
   localparam logic [5:0] fn_slt = 6'd42;

   ////////////////////////////////////////////////////////////
   // Control
   ////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_op_t;

   typedef enum logic [1:0] {wb_alu, wb_load, wb_upper} wb_sel_t;

   // All zero is a bubble
   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src;
      logic    reg_dst;
      logic    branch_eq;
      logic    branch_ne;
      logic    jump;
      alu_op_t alu_op;
      wb_sel_t wb_sel;
   } ctrl_t;

   ////////////////////////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [reg_addr_width-1:0] rd;
      logic [4:0]                shamt;
      logic [5:0]                funct;
   } r_view_t;

   typedef struct packed {
      logic [5:0]                opcode;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [15:0]               imm;
   } i_view_t;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] index;
   } j_view_t;

   typedef union packed {
      r_view_t r;
      i_view_t i;
      j_view_t j;
   } instr_t;

   ////////////////////////////////////////////////////////////
   // Pipeline registers
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      instr_t                instr;
      logic [word_width-1:0] pc_plus1;
   } if_id_t;

   typedef struct packed {
      ctrl_t                     ctrl;
      logic [word_width-1:0]     pc_plus1;
      logic [word_width-1:0]     rs_data;
      logic [word_width-1:0]     rt_data;
      logic [word_width-1:0]     imm_ext;
      logic [word_width-1:0]     upper;
      logic [reg_addr_width-1:0] rs;
      logic [reg_addr_width-1:0] rt;
      logic [reg_addr_width-1:0] rd;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                     ctrl;
      logic [word_width-1:0]     alu_result;
      logic [word_width-1:0]     store_data;
      logic [word_width-1:0]     upper;
      logic [reg_addr_width-1:0] dst;
   } ex_mem_t;

   // Memory/write-back register, also the retire port
   typedef struct packed {
      logic                      valid;
      logic [reg_addr_width-1:0] dst;
      logic [word_width-1:0]     data;
   } retire_t;

endpackage

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file
(
   input  logic                                 CLK,
   input  logic                                 RESET,
   input  logic [mips_pkg::reg_addr_width-1:0]  rs_addr,
   input  logic [mips_pkg::reg_addr_width-1:0]  rt_addr,
   input  logic                                 write_en,
   input  logic [mips_pkg::reg_addr_width-1:0]  write_addr,
   input  logic [mips_pkg::word_width-1:0]      write_data,
   output logic [mips_pkg::word_width-1:0]      rs_data,
   output logic [mips_pkg::word_width-1:0]      rt_data
);

   logic [mips_pkg::word_width-1:0] regs [2**mips_pkg::reg_addr_width];
   logic                            write_live;

   // Register 0 is never written
   assign write_live = write_en && (write_addr != '0);

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         for (int i = 0; i < 2**mips_pkg::reg_addr_width; i++)
            regs[i] <= '0;
      end
      else if (write_live)
         regs[write_addr] <= write_data;
   end

   // Write-through so decode sees the value retiring this cycle
   assign rs_data = (write_live && write_addr == rs_addr) ? write_data : regs[rs_addr];
   assign rt_data = (write_live && write_addr == rt_addr) ? write_data : regs[rt_addr];

endmodule

// ==== verification/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;

   localparam int test_count      = 5;
   localparam int cycles_per_test = 60;
   localparam int max_run_cycles  = test_count * cycles_per_test;
   // Words written per test, no-ops after the program
   localparam int prog_words      = 64;
   localparam int drain_cycles    = 12;

   logic                                  CLK;
   logic                                  RESET;
   logic                                  prog_write;
   logic [mips_pkg::imem_addr_width-1:0]  prog_addr;
   logic [mips_pkg::word_width-1:0]       prog_data;
   mips_pkg::retire_t                     retire;

   logic [mips_pkg::word_width-1:0] program_q [$];
   mips_pkg::retire_t               expected_q [$];
   mips_pkg::retire_t               captured_q [$];
   integer                          seed = 32'h6f91;
   int                              errors = 0;
   int                              checks = 0;
   int                              run_cycles = 0;

   mips_core dut_i
   (
      .CLK        (CLK),
      .RESET      (RESET),
      .prog_write (prog_write),
      .prog_addr  (prog_addr),
      .prog_data  (prog_data),
      .retire     (retire)
   );

   initial
   begin
      CLK = 1'b0;
      forever
         #20 CLK = ~CLK;
   end

   // Retire monitor, sampled mid-cycle
   always @(negedge CLK)
   begin
      if (retire.valid)
         captured_q.push_back(retire);
   end

   // Watchdog over the cycles the core actually runs
   initial
   begin
      while (run_cycles < max_run_cycles)
      begin
         @(posedge CLK);
         if (!RESET)
            run_cycles++;
      end
      $display("Timeout: the core ran %0d cycles without finishing the tests", run_cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Finished with errors");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Instruction encoding
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] r_format
   (
      input logic [5:0] funct,
      input logic [4:0] rd,
      input logic [4:0] rs,
      input logic [4:0] rt
   );
      return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [31:0] i_format
   (
      input logic [5:0]  opcode,
      input logic [4:0]  rt,
      input logic [4:0]  rs,
      input logic [15:0] imm
   );
      return {opcode, rs, rt, imm};
   endfunction

   function automatic logic [31:0] j_format(input logic [25:0] index);
      return {mips_pkg::op_j, index};
   endfunction

   function automatic logic [31:0] sign_extend(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   task automatic random_imm(output logic [15:0] imm);
      logic [31:0] r;
      r   = $random(seed);
      imm = r[15:0];
   endtask

   task automatic emit(input logic [31:0] word);
      program_q.push_back(word);
   endtask

   task automatic expect_write(input logic [4:0] dst, input logic [31:0] data);
      mips_pkg::retire_t e;
      e.valid = 1'b1;
      e.dst   = dst;
      e.data  = data;
      expected_q.push_back(e);
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_retire
   (
      input string             name,
      input mips_pkg::retire_t exp,
      input mips_pkg::retire_t act
   );
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("Error: %s expected r%0d = %h, actual r%0d = %h",
                  name, exp.dst, exp.data, act.dst, act.data);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (act != exp)
      begin
         errors++;
         $display("Error: %s expected %0d retire events, actual %0d", name, exp, act);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Program load and run
   ////////////////////////////////////////////////////////////
   task automatic load_program();
      for (int a = 0; a < prog_words; a++)
      begin
         @(negedge CLK);
         prog_write = 1'b1;
         prog_addr  = a[mips_pkg::imem_addr_width-1:0];
         prog_data  = (a < program_q.size()) ? program_q[a] : '0;
      end
      @(negedge CLK);
      prog_write = 1'b0;
   endtask

   task automatic run_program(input string name);
      int idx;
      RESET = 1'b1;
      repeat (8) @(negedge CLK);
      load_program();
      captured_q.delete();
      RESET = 1'b0;
      while (captured_q.size() < expected_q.size())
         @(negedge CLK);
      // Late strays from skipped instructions would show up here
      repeat (drain_cycles) @(negedge CLK);
      check_count(name, expected_q.size(), captured_q.size());
      for (idx = 0; idx < expected_q.size() && idx < captured_q.size(); idx++)
         check_retire(name, expected_q[idx], captured_q[idx]);
      RESET = 1'b1;
      program_q.delete();
      expected_q.delete();
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////
   task automatic alu_immediates();
      logic [15:0] imm;
      logic [31:0] v [4];
      logic [4:0]  dst;
      for (int k = 0; k < 4; k++)
      begin
         random_imm(imm);
         v[k] = sign_extend(imm);
         dst  = k[4:0] + 5'd1;
         emit(i_format(mips_pkg::op_addi, dst, 5'd0, imm));
         expect_write(dst, v[k]);
      end
      emit(r_format(mips_pkg::fn_add, 5'd5, 5'd1, 5'd2));
      expect_write(5'd5, v[0] + v[1]);
      emit(i_format(mips_pkg::op_addi, 5'd10, 5'd0, 16'd7));
      expect_write(5'd10, 32'd7);
      emit(r_format(mips_pkg::fn_sub, 5'd6, 5'd1, 5'd2));
      expect_write(5'd6, v[0] - v[1]);
      emit(r_format(mips_pkg::fn_and, 5'd7, 5'd3, 5'd4));
      expect_write(5'd7, v[2] & v[3]);
      emit(i_format(mips_pkg::op_addi, 5'd11, 5'd0, 16'hfffd));
      expect_write(5'd11, 32'hffff_fffd);
      emit(r_format(mips_pkg::fn_or, 5'd8, 5'd3, 5'd4));
      expect_write(5'd8, v[2] | v[3]);
      // Signed compare both ways
      emit(r_format(mips_pkg::fn_slt, 5'd9, 5'd1, 5'd2));
      expect_write(5'd9, ($signed(v[0]) < $signed(v[1])) ? 32'd1 : 32'd0);
      emit(r_format(mips_pkg::fn_slt, 5'd12, 5'd2, 5'd1));
      expect_write(5'd12, ($signed(v[1]) < $signed(v[0])) ? 32'd1 : 32'd0);
      run_program("alu_immediates");
   endtask

   task automatic forwarding_chain();
      logic [15:0] imm;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] s3;
      logic [31:0] s4;
      logic [31:0] s5;
      logic [31:0] s6;
      random_imm(imm);
      a = sign_extend(imm);
      random_imm(imm);
      b  = sign_extend(imm);
      s3 = a + b;
      s4 = s3 + a;
      s5 = s4 + s3;
      s6 = s5 + s5;
      emit(i_format(mips_pkg::op_addi, 5'd1, 5'd0, a[15:0]));
      emit(i_format(mips_pkg::op_addi, 5'd2, 5'd0, b[15:0]));
      emit(r_format(mips_pkg::fn_add, 5'd3, 5'd1, 5'd2));
      emit(r_format(mips_pkg::fn_add, 5'd4, 5'd3, 5'd1));
      emit(r_format(mips_pkg::fn_add, 5'd5, 5'd4, 5'd3));
      emit(r_format(mips_pkg::fn_add, 5'd6, 5'd5, 5'd5));
      emit(r_format(mips_pkg::fn_add, 5'd7, 5'd6, 5'd4));
      expect_write(5'd1, a);
      expect_write(5'd2, b);
      expect_write(5'd3, s3);
      expect_write(5'd4, s4);
      expect_write(5'd5, s5);
      expect_write(5'd6, s6);
      expect_write(5'd7, s6 + s4);
      run_program("forwarding_chain");
   endtask

   task automatic load_store_use();
      logic [15:0] imm;
      logic [31:0] v1;
      logic [31:0] v2;
      random_imm(imm);
      v1 = sign_extend(imm);
      random_imm(imm);
      v2 = sign_extend(imm);
      emit(i_format(mips_pkg::op_addi, 5'd1, 5'd0, v1[15:0]));
      emit(i_format(mips_pkg::op_addi, 5'd2, 5'd0, v2[15:0]));
      emit(i_format(mips_pkg::op_addi, 5'd3, 5'd0, 16'd5));
      emit(i_format(mips_pkg::op_sw, 5'd1, 5'd3, 16'd0));
      emit(i_format(mips_pkg::op_sw, 5'd2, 5'd3, 16'd1));
      // Each load is used by the very next instruction
      emit(i_format(mips_pkg::op_lw, 5'd4, 5'd3, 16'd0));
      emit(r_format(mips_pkg::fn_add, 5'd5, 5'd4, 5'd1));
      emit(i_format(mips_pkg::op_lw, 5'd6, 5'd3, 16'd1));
      emit(r_format(mips_pkg::fn_sub, 5'd7, 5'd6, 5'd4));
      emit(r_format(mips_pkg::fn_add, 5'd8, 5'd7, 5'd6));
      expect_write(5'd1, v1);
      expect_write(5'd2, v2);
      expect_write(5'd3, 32'd5);
      expect_write(5'd4, v1);
      expect_write(5'd5, v1 + v1);
      expect_write(5'd6, v2);
      expect_write(5'd7, v2 - v1);
      expect_write(5'd8, (v2 - v1) + v2);
      run_program("load_store_use");
   endtask

   task automatic branch_paths();
      emit(i_format(mips_pkg::op_addi, 5'd1, 5'd0, 16'd9));
      emit(i_format(mips_pkg::op_addi, 5'd2, 5'd0, 16'd9));
      emit(i_format(mips_pkg::op_addi, 5'd3, 5'd0, 16'd4));
      emit(i_format(mips_pkg::op_addi, 5'd9, 5'd0, 16'd30));
      // beq taken to word 7
      emit(i_format(mips_pkg::op_beq, 5'd2, 5'd1, 16'd2));
      emit(i_format(mips_pkg::op_addi, 5'd10, 5'd0, 16'd1));
      emit(i_format(mips_pkg::op_addi, 5'd11, 5'd0, 16'd2));
      // bne not taken
      emit(i_format(mips_pkg::op_bne, 5'd2, 5'd1, 16'd2));
      emit(i_format(mips_pkg::op_addi, 5'd12, 5'd0, 16'd3));
      // bne taken to word 11
      emit(i_format(mips_pkg::op_bne, 5'd3, 5'd1, 16'd1));
      emit(i_format(mips_pkg::op_addi, 5'd13, 5'd0, 16'd4));
      // beq not taken
      emit(i_format(mips_pkg::op_beq, 5'd3, 5'd1, 16'd1));
      emit(i_format(mips_pkg::op_addi, 5'd14, 5'd0, 16'd5));
      emit(i_format(mips_pkg::op_addi, 5'd15, 5'd0, 16'd6));
      expect_write(5'd1, 32'd9);
      expect_write(5'd2, 32'd9);
      expect_write(5'd3, 32'd4);
      expect_write(5'd9, 32'd30);
      expect_write(5'd12, 32'd3);
      expect_write(5'd14, 32'd5);
      expect_write(5'd15, 32'd6);
      run_program("branch_paths");
   endtask

   task automatic jump_lui_zero();
      logic [15:0] u;
      random_imm(u);
      emit(i_format(mips_pkg::op_addi, 5'd1, 5'd0, 16'd21));
      emit(j_format(26'd4));
      emit(i_format(mips_pkg::op_addi, 5'd2, 5'd0, 16'd1));
      emit(i_format(mips_pkg::op_addi, 5'd3, 5'd0, 16'd2));
      emit(i_format(mips_pkg::op_lui, 5'd4, 5'd0, u));
      // Write to register 0 is dropped
      emit(i_format(mips_pkg::op_addi, 5'd0, 5'd0, 16'd55));
      emit(r_format(mips_pkg::fn_add, 5'd5, 5'd0, 5'd1));
      emit(r_format(mips_pkg::fn_or, 5'd6, 5'd4, 5'd0));
      emit(j_format(26'd10));
      emit(i_format(mips_pkg::op_addi, 5'd7, 5'd0, 16'd3));
      emit(i_format(mips_pkg::op_addi, 5'd8, 5'd0, 16'd8));
      expect_write(5'd1, 32'd21);
      expect_write(5'd4, {u, 16'h0000});
      expect_write(5'd5, 32'd21);
      expect_write(5'd6, {u, 16'h0000});
      expect_write(5'd8, 32'd8);
      run_program("jump_lui_zero");
   endtask

   initial
   begin
      RESET      = 1'b1;
      prog_write = 1'b0;
      prog_addr  = '0;
      prog_data  = '0;
      alu_immediates();
      forwarding_chain();
      load_store_use();
      branch_paths();
      jump_lui_zero();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
